// File: verilog/mipsExecPkg.sv
`default_nettype none

package mipsExecPkg;

    typedef logic [31:0] wordT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

    typedef enum logic [5:0] {
        opZero  = 6'd0,  opAddiu = 6'd1,  opAddi  = 6'd2,  opMul   = 6'd3,
        opLui   = 6'd4,  opBltz  = 6'd5,  opBeq   = 6'd6,  opBne   = 6'd7,
        opBgtz  = 6'd8,  opBlez  = 6'd9,  opBgez  = 6'd10, opJump  = 6'd11,
        opAndi  = 6'd12, opOri   = 6'd13, opXori  = 6'd14, opSeb   = 6'd15,
        opSlti  = 6'd16, opSltiu = 6'd17, opSrl   = 6'd18, opRotr  = 6'd19,
        opSrlv  = 6'd20, opSeh   = 6'd21, opRotrv = 6'd22, opExi   = 6'd23,
        opLa    = 6'd24
    } aluOpE;

    typedef enum logic [5:0] {
        ctrlAdd   = 6'd0,  ctrlAddu  = 6'd1,  ctrlSub   = 6'd2,  ctrlMul   = 6'd3,
        ctrlMult  = 6'd4,  ctrlMultu = 6'd5,  ctrlMadd  = 6'd6,  ctrlMsub  = 6'd7,
        ctrlBgez  = 6'd8,  ctrlBeq   = 6'd9,  ctrlBne   = 6'd10, ctrlBgtz  = 6'd11,
        ctrlBlez  = 6'd12, ctrlBltz  = 6'd13, ctrlJump  = 6'd14, ctrlSrav  = 6'd15,
        ctrlRotrv = 6'd16, ctrlLui   = 6'd17, ctrlAnd   = 6'd18, ctrlOr    = 6'd19,
        ctrlNor   = 6'd20, ctrlXor   = 6'd21, ctrlSeh   = 6'd22, ctrlSll   = 6'd23,
        ctrlSrl   = 6'd24, ctrlMovn  = 6'd25, ctrlMovz  = 6'd26, ctrlRotr  = 6'd27,
        ctrlSra   = 6'd28, ctrlSeb   = 6'd29, ctrlSlt   = 6'd30, ctrlSltu  = 6'd31,
        ctrlMthi  = 6'd32, ctrlMtlo  = 6'd33, ctrlMfhi  = 6'd34, ctrlMflo  = 6'd35,
        ctrlSllv  = 6'd36, ctrlSrlv  = 6'd37, ctrlEh    = 6'd38, ctrlIh    = 6'd39,
        ctrlDh    = 6'd40, ctrlEb    = 6'd41, ctrlIb    = 6'd42, ctrlAbs   = 6'd43,
        ctrlLa    = 6'd44, ctrlSubu  = 6'd45
    } aluCtrlE;

    typedef struct packed {
        logic [29:0] reserved;
        logic        illegal;
        logic        branchTaken; // Bit 0
    } statusT;

    // Word offsets on the bus
    localparam logic [2:0] regOpA    = 3'd0;
    localparam logic [2:0] regOpB    = 3'd1;
    localparam logic [2:0] regInstr  = 3'd2; // Write launches
    localparam logic [2:0] regResult = 3'd3;
    localparam logic [2:0] regHi     = 3'd4;
    localparam logic [2:0] regLo     = 3'd5;
    localparam logic [2:0] regStatus = 3'd6;

endpackage

`default_nettype wire

// File: verilog/execIf.sv
`timescale 1ns/1ps
`default_nettype none

interface aluCmdIf import mipsExecPkg::*; (
    input logic clk
);
    instrU   instr;
    wordT    opA;
    wordT    opB;
    aluOpE   aluOp;
    wordT    operandB;   // Immediate or opB
    logic    illegalOp;  // Opcode out of scope
    aluCtrlE aluCtrl;
    logic    illegal;    // Opcode or funct out of scope

    modport source  (output instr, opA, opB);
    modport decode  (input instr, opB, output aluOp, operandB, illegalOp);
    modport control (input clk, instr, aluOp, illegalOp, output aluCtrl, illegal);
    modport execute (input instr, opA, operandB, aluCtrl, illegal);
endinterface

interface execResultIf import mipsExecPkg::*;;
    wordT   result;
    wordT   newHi;
    wordT   newLo;
    logic   writeResult;
    logic   writeHiLo;
    logic   branchTaken;
    logic   illegal;
    wordT   hi;
    wordT   lo;
    wordT   storedResult;
    statusT status;

    modport execute (input hi, lo,
                     output result, newHi, newLo, writeResult, writeHiLo, branchTaken, illegal);
    modport storage (input result, newHi, newLo, writeResult, writeHiLo, branchTaken, illegal,
                     output hi, lo, storedResult, status);
    modport reader  (input storedResult, hi, lo, status);
endinterface

`default_nettype wire

// File: verilog/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode import mipsExecPkg::*; (
    aluCmdIf.decode cmd
);
    localparam logic [5:0] opcSpecial  = 6'b000000,
                           opcRegimm   = 6'b000001,
                           opcBeq      = 6'b000100,
                           opcBne      = 6'b000101,
                           opcBlez     = 6'b000110,
                           opcBgtz     = 6'b000111,
                           opcAddi     = 6'b001000,
                           opcAddiu    = 6'b001001,
                           opcSlti     = 6'b001010,
                           opcSltiu    = 6'b001011,
                           opcAndi     = 6'b001100,
                           opcOri      = 6'b001101,
                           opcXori     = 6'b001110,
                           opcLui      = 6'b001111,
                           opcSpecial2 = 6'b011100,
                           opcSpecial3 = 6'b011111;

    wordT immSext;
    wordT immZext;

    assign immSext = {{16{cmd.instr.i.imm[15]}}, cmd.instr.i.imm};
    assign immZext = {16'h0000, cmd.instr.i.imm};

    always_comb begin
        cmd.aluOp     = opZero;
        cmd.operandB  = cmd.opB;
        cmd.illegalOp = 1'b0;
        case (cmd.instr.i.opcode)
            opcSpecial  : cmd.aluOp = opZero;
            opcRegimm   : begin
                case (cmd.instr.i.rt) // rt picks the REGIMM branch
                    5'b00000: cmd.aluOp = opBltz;
                    5'b00001: cmd.aluOp = opBgez;
                    default : cmd.illegalOp = 1'b1;
                endcase
            end
            opcBeq      : cmd.aluOp = opBeq;
            opcBne      : cmd.aluOp = opBne;
            opcBlez     : cmd.aluOp = opBlez;
            opcBgtz     : cmd.aluOp = opBgtz;
            opcSpecial2 : cmd.aluOp = opMul;
            opcSpecial3 : cmd.aluOp = opSeb;  // SEB and SEH split on shamt later
            opcAddi, opcAddiu, opcSlti, opcSltiu: begin
                cmd.operandB = immSext;
                case (cmd.instr.i.opcode[1:0])
                    2'b00  : cmd.aluOp = opAddi;
                    2'b01  : cmd.aluOp = opAddiu;
                    2'b10  : cmd.aluOp = opSlti;
                    default: cmd.aluOp = opSltiu;
                endcase
            end
            opcAndi, opcOri, opcXori: begin
                cmd.operandB = immZext;
                case (cmd.instr.i.opcode[1:0])
                    2'b00  : cmd.aluOp = opAndi;
                    2'b01  : cmd.aluOp = opOri;
                    default: cmd.aluOp = opXori;
                endcase
            end
            opcLui      : begin
                cmd.aluOp    = opLui;
                cmd.operandB = {cmd.instr.i.imm, 16'h0000};
            end
            default     : cmd.illegalOp = 1'b1; // Jumps, loads and the rest
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/aluControl.sv
`timescale 1ns/1ps
`default_nettype none

module aluControl import mipsExecPkg::*; (
    aluCmdIf.control cmd
);
    // SPECIAL function field
    localparam logic [5:0] functSll  = 6'b000000, functSrl  = 6'b000010, functSra  = 6'b000011,
                           functSllv = 6'b000100, functSrlv = 6'b000110, functSrav = 6'b000111,
                           functMfhi = 6'b010000, functMthi = 6'b010001, functMflo = 6'b010010,
                           functMtlo = 6'b010011, functMult = 6'b011000, functMultu = 6'b011001,
                           functAdd  = 6'b100000, functAddu = 6'b100001, functSub  = 6'b100010,
                           functSubu = 6'b100011, functAnd  = 6'b100100, functOr   = 6'b100101,
                           functXor  = 6'b100110, functNor  = 6'b100111, functSlt  = 6'b101010,
                           functSltu = 6'b101011;
    // SPECIAL2 and SPECIAL3 function field
    localparam logic [5:0] functMadd = 6'b000000, functMul = 6'b000010, functMsub = 6'b000100,
                           functBshfl = 6'b100000;

    logic [5:0] funct;
    logic       badFunct;

    assign funct = cmd.instr.r.funct;

    always_comb begin
        cmd.aluCtrl = ctrlAdd;
        badFunct    = 1'b0;
        case (cmd.aluOp)
            opZero: begin
                case (funct)
                    functSll  : cmd.aluCtrl = ctrlSll;
                    functSrl  : cmd.aluCtrl = cmd.instr.r.rs[0] ? ctrlRotr : ctrlSrl;
                    functSra  : cmd.aluCtrl = ctrlSra;
                    functSllv : cmd.aluCtrl = ctrlSllv;
                    functSrlv : cmd.aluCtrl = cmd.instr.r.shamt[0] ? ctrlRotr : ctrlSrlv;
                    functSrav : cmd.aluCtrl = ctrlSrav;
                    functMfhi : cmd.aluCtrl = ctrlMfhi;
                    functMthi : cmd.aluCtrl = ctrlMthi;
                    functMflo : cmd.aluCtrl = ctrlMflo;
                    functMtlo : cmd.aluCtrl = ctrlMtlo;
                    functMult : cmd.aluCtrl = ctrlMult;
                    functMultu: cmd.aluCtrl = ctrlMultu;
                    functAdd  : cmd.aluCtrl = ctrlAdd;
                    functAddu : cmd.aluCtrl = ctrlAddu;
                    functSub  : cmd.aluCtrl = ctrlSub;
                    functSubu : cmd.aluCtrl = ctrlSubu;
                    functAnd  : cmd.aluCtrl = ctrlAnd;
                    functOr   : cmd.aluCtrl = ctrlOr;
                    functXor  : cmd.aluCtrl = ctrlXor;
                    functNor  : cmd.aluCtrl = ctrlNor;
                    functSlt  : cmd.aluCtrl = ctrlSlt;
                    functSltu : cmd.aluCtrl = ctrlSltu;
                    default   : badFunct = 1'b1; // MOVN, MOVZ, JR land here
                endcase
            end
            opMul: begin
                case (funct)
                    functMul : cmd.aluCtrl = ctrlMul;
                    functMadd: cmd.aluCtrl = ctrlMadd;
                    functMsub: cmd.aluCtrl = ctrlMsub;
                    default  : badFunct = 1'b1;
                endcase
            end
            opSeb: begin
                if (funct == functBshfl && cmd.instr.r.shamt == 5'b10000) begin
                    cmd.aluCtrl = ctrlSeb;
                end else if (funct == functBshfl && cmd.instr.r.shamt == 5'b11000) begin
                    cmd.aluCtrl = ctrlSeh;
                end else begin
                    badFunct = 1'b1;
                end
            end
            opAddiu : cmd.aluCtrl = ctrlAddu;
            opAddi  : cmd.aluCtrl = ctrlAdd;
            opLui   : cmd.aluCtrl = ctrlLui;
            opBltz  : cmd.aluCtrl = ctrlBltz;
            opBgez  : cmd.aluCtrl = ctrlBgez;
            opBeq   : cmd.aluCtrl = ctrlBeq;
            opBne   : cmd.aluCtrl = ctrlBne;
            opBgtz  : cmd.aluCtrl = ctrlBgtz;
            opBlez  : cmd.aluCtrl = ctrlBlez;
            opAndi  : cmd.aluCtrl = ctrlAnd;
            opOri   : cmd.aluCtrl = ctrlOr;
            opXori  : cmd.aluCtrl = ctrlXor;
            opSeh   : cmd.aluCtrl = ctrlSeh;
            opSlti  : cmd.aluCtrl = ctrlSlt;
            opSltiu : cmd.aluCtrl = ctrlSltu;
            opSrl   : cmd.aluCtrl = ctrlSrl;
            opSrlv  : cmd.aluCtrl = ctrlSrlv;
            opRotr, opRotrv: cmd.aluCtrl = ctrlRotr; // Amount source chosen in execute
            default : badFunct = 1'b1; // Jump, LA and custom classes
        endcase
    end

    assign cmd.illegal = cmd.illegalOp | badFunct;

    aCtrlDefined: assert property (@(posedge cmd.clk)
        !$isunknown(cmd.aluCtrl) && (cmd.aluCtrl <= ctrlSubu))
        else $error("aluControl: undefined control code %0d", cmd.aluCtrl);

endmodule

`default_nettype wire

// File: verilog/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute import mipsExecPkg::*; (
    aluCmdIf.execute     cmd,
    execResultIf.execute res
);
    wordT        a;
    wordT        b;
    logic [4:0]  shAmt;
    logic [63:0] rotWide;
    logic [63:0] prodS;
    logic [63:0] prodU;
    logic [63:0] acc;

    assign a = cmd.opA;
    assign b = cmd.operandB;
    // Funct bit 2 marks the variable forms, amount from rs
    assign shAmt   = cmd.instr.r.funct[2] ? a[4:0] : cmd.instr.r.shamt;
    assign rotWide = {b, b} >> shAmt;
    assign prodS   = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    assign prodU   = {32'h0, a} * {32'h0, b};
    assign acc     = {res.hi, res.lo};

    always_comb begin
        res.result      = '0;
        res.newHi       = res.hi;
        res.newLo       = res.lo;
        res.writeResult = 1'b1;
        res.writeHiLo   = 1'b0;
        res.branchTaken = 1'b0;
        case (cmd.aluCtrl)
            ctrlAdd, ctrlAddu : res.result = a + b;
            ctrlSub, ctrlSubu : res.result = a - b;
            ctrlAnd           : res.result = a & b;
            ctrlOr            : res.result = a | b;
            ctrlXor           : res.result = a ^ b;
            ctrlNor           : res.result = ~(a | b);
            ctrlSll, ctrlSllv : res.result = b << shAmt;
            ctrlSrl, ctrlSrlv : res.result = b >> shAmt;
            ctrlSra, ctrlSrav : res.result = $signed(b) >>> shAmt;
            ctrlRotr          : res.result = rotWide[31:0];
            ctrlSlt           : res.result = {31'h0, $signed(a) < $signed(b)};
            ctrlSltu          : res.result = {31'h0, a < b};
            ctrlLui           : res.result = b; // Upper immediate already formed
            ctrlSeb           : res.result = {{24{b[7]}}, b[7:0]};
            ctrlSeh           : res.result = {{16{b[15]}}, b[15:0]};
            ctrlMul           : res.result = prodS[31:0];
            ctrlMfhi          : res.result = res.hi;
            ctrlMflo          : res.result = res.lo;
            ctrlMult, ctrlMultu, ctrlMadd, ctrlMsub: begin
                res.writeResult = 1'b0;
                res.writeHiLo   = 1'b1;
                case (cmd.aluCtrl)
                    ctrlMult : {res.newHi, res.newLo} = prodS;
                    ctrlMultu: {res.newHi, res.newLo} = prodU;
                    ctrlMadd : {res.newHi, res.newLo} = acc + prodS;
                    default  : {res.newHi, res.newLo} = acc - prodS;
                endcase
            end
            ctrlMthi: begin
                res.writeResult = 1'b0;
                res.writeHiLo   = 1'b1;
                res.newHi       = a;
            end
            ctrlMtlo: begin
                res.writeResult = 1'b0;
                res.writeHiLo   = 1'b1;
                res.newLo       = a;
            end
            ctrlBeq, ctrlBne, ctrlBltz, ctrlBgez, ctrlBgtz, ctrlBlez: begin
                res.writeResult = 1'b0; // Branches only report the flag
                case (cmd.aluCtrl)
                    ctrlBeq : res.branchTaken = (a == b);
                    ctrlBne : res.branchTaken = (a != b);
                    ctrlBltz: res.branchTaken = a[31];
                    ctrlBgez: res.branchTaken = !a[31];
                    ctrlBgtz: res.branchTaken = !a[31] && (a != '0);
                    default : res.branchTaken = a[31] || (a == '0);
                endcase
            end
            default: res.writeResult = 1'b0;
        endcase
        // Illegal instruction touches only status
        if (cmd.illegal) begin
            res.writeResult = 1'b0;
            res.writeHiLo   = 1'b0;
            res.branchTaken = 1'b0;
        end
    end

    assign res.illegal = cmd.illegal;

endmodule

`default_nettype wire

// File: verilog/resultRegs.sv
`timescale 1ns/1ps
`default_nettype none

module resultRegs import mipsExecPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  logic         launch,
    execResultIf.storage res
);
    statusT nextStatus;

    always_comb begin
        nextStatus             = '0;
        nextStatus.branchTaken = res.branchTaken;
        nextStatus.illegal     = res.illegal;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            res.storedResult <= '0;
            res.hi           <= '0;
            res.lo           <= '0;
            res.status       <= '0;
        end else if (launch) begin
            if (res.writeResult) begin
                res.storedResult <= res.result;
            end
            if (res.writeHiLo) begin
                res.hi <= res.newHi;
                res.lo <= res.newLo;
            end
            res.status <= nextStatus; // Rewritten on every launch
        end
    end

    // Enables come from the execute stage decode
    aOneTarget: assert property (@(posedge clk) disable iff (!rstN)
        !(res.writeResult && res.writeHiLo))
        else $error("resultRegs: result and HI/LO written by one instruction");

endmodule

`default_nettype wire

// File: verilog/wbExecSlave.sv
`timescale 1ns/1ps
`default_nettype none

module wbExecSlave import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [2:0]  wbAdr,
    input  wordT        wbDatW,
    output wordT        wbDatR,
    output logic        wbAck,
    aluCmdIf.source     cmd,
    execResultIf.reader res,
    output logic        launch
);
    logic req;
    logic wrStrobe;

    assign req      = wbCyc && wbStb;
    assign wrStrobe = req && wbAck && wbWe; // Writes land on the acknowledge edge

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbAck     <= 1'b0;
            launch    <= 1'b0;
            cmd.instr <= '0;
            cmd.opA   <= '0;
            cmd.opB   <= '0;
        end else begin
            wbAck  <= req && !wbAck; // One ack per request
            launch <= wrStrobe && (wbAdr == regInstr);
            if (wrStrobe && wbAdr == regInstr) begin
                cmd.instr <= wbDatW;
            end
            if (wrStrobe && wbAdr == regOpA) begin
                cmd.opA <= wbDatW;
            end
            if (wrStrobe && wbAdr == regOpB) begin
                cmd.opB <= wbDatW;
            end
        end
    end

    always_comb begin
        case (wbAdr)
            regOpA   : wbDatR = cmd.opA;
            regOpB   : wbDatR = cmd.opB;
            regResult: wbDatR = res.storedResult;
            regHi    : wbDatR = res.hi;
            regLo    : wbDatR = res.lo;
            regStatus: wbDatR = res.status;
            default  : wbDatR = '0; // Instruction is write-only
        endcase
    end

    aAckWithStb: assert property (@(posedge clk) disable iff (!rstN) wbAck |-> wbStb)
        else $error("wbExecSlave: acknowledge without strobe");

endmodule

`default_nettype wire

// File: verilog/mipsExecUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecUnit import mipsExecPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wbCyc,
    input  logic       wbStb,
    input  logic       wbWe,
    input  logic [2:0] wbAdr,
    input  wordT       wbDatW,
    output wordT       wbDatR,
    output logic       wbAck
);
    logic launch;

    aluCmdIf     cmdIf (.clk(clk));
    execResultIf resIf ();

    wbExecSlave i_slave (
        .clk    (clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .cmd    (cmdIf.source),
        .res    (resIf.reader),
        .launch (launch)
    );

    instrDecode i_decode (.cmd(cmdIf.decode));

    aluControl i_control (.cmd(cmdIf.control));

    aluExecute i_execute (
        .cmd (cmdIf.execute),
        .res (resIf.execute)
    );

    resultRegs i_regs (
        .clk    (clk),
        .rstN   (rstN),
        .launch (launch),
        .res    (resIf.storage)
    );

endmodule

`default_nettype wire

// File: verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);
    localparam int halfPeriod = 5; // 10 ns clock

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1; // Released just after the third edge
    end

endmodule

`default_nettype wire

// File: verif/mipsExecUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecUnitTb import mipsExecPkg::*; ();

    localparam string goldenPath = "verif/execGolden.txt";

    logic       clk;
    logic       rstN;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    logic [2:0] wbAdr;
    wordT       wbDatW;
    wordT       wbDatR;
    logic       wbAck;

    // One entry per golden line
    wordT   vecOpA[$];
    wordT   vecOpB[$];
    wordT   vecInstr[$];
    wordT   vecResult[$];
    wordT   vecHi[$];
    wordT   vecLo[$];
    statusT vecStatus[$];

    bit loaded;
    int cycleLimit;

    tbClock i_clock (
        .clk  (clk),
        .rstN (rstN)
    );

    mipsExecUnit i_dut (
        .clk    (clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkWord(input string what, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s expected %h, got %h", $time, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic checkStatus(input string what, input statusT expected, input statusT actual);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s expected illegal %b taken %b (%h), got %b %b (%h)",
                     $time, what, expected.illegal, expected.branchTaken, expected,
                     actual.illegal, actual.branchTaken, actual);
            $display("** FAIL **");
            $fatal(1, "Status mismatch");
        end
    endtask

    // One Wishbone classic transfer, held until the acknowledge is seen
    task automatic busAccess(input logic we, input logic [2:0] adr, input wordT wdata,
                             output wordT rdata);
        @(posedge clk);
        #1;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (wbAck !== 1'b1);
        rdata = wbDatR; // Stable in the acknowledge cycle
        @(posedge clk);
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic loadGolden();
        int    fd;
        int    fields;
        string line;
        wordT  a;
        wordT  b;
        wordT  ins;
        wordT  r;
        wordT  h;
        wordT  l;
        wordT  s;
        fd = $fopen(goldenPath, "r");
        if (fd == 0) begin
            stopOnError({"Could not open golden file ", goldenPath});
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue; // Header or trailing empty line
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h", a, b, ins, r, h, l, s);
            if (fields != 7) begin
                stopOnError({"Malformed golden line: ", line});
            end
            vecOpA.push_back(a);
            vecOpB.push_back(b);
            vecInstr.push_back(ins);
            vecResult.push_back(r);
            vecHi.push_back(h);
            vecLo.push_back(l);
            vecStatus.push_back(statusT'(s));
        end
        $fclose(fd);
    endtask

    task automatic checkResetState();
        wordT rdata;
        busAccess(1'b0, regOpA, '0, rdata);
        checkWord("operand A after reset", '0, rdata);
        busAccess(1'b0, regOpB, '0, rdata);
        checkWord("operand B after reset", '0, rdata);
        busAccess(1'b0, regResult, '0, rdata);
        checkWord("result after reset", '0, rdata);
        busAccess(1'b0, regHi, '0, rdata);
        checkWord("HI after reset", '0, rdata);
        busAccess(1'b0, regLo, '0, rdata);
        checkWord("LO after reset", '0, rdata);
        busAccess(1'b0, regStatus, '0, rdata);
        checkStatus("status after reset", '0, statusT'(rdata));
        busAccess(1'b0, 3'd7, '0, rdata);
        checkWord("unmapped offset", '0, rdata);
        busAccess(1'b0, regInstr, '0, rdata);
        checkWord("write-only instruction offset", '0, rdata);
    endtask

    task automatic runVector(input int idx);
        wordT  rdata;
        string tag;
        tag = $sformatf("vector %0d instr %h", idx, vecInstr[idx]);
        busAccess(1'b1, regOpA, vecOpA[idx], rdata);
        busAccess(1'b1, regOpB, vecOpB[idx], rdata);
        busAccess(1'b0, regOpA, '0, rdata);
        checkWord({tag, " operand A readback"}, vecOpA[idx], rdata);
        busAccess(1'b0, regOpB, '0, rdata);
        checkWord({tag, " operand B readback"}, vecOpB[idx], rdata);
        busAccess(1'b1, regInstr, vecInstr[idx], rdata); // Launches
        busAccess(1'b0, regResult, '0, rdata);
        checkWord({tag, " result"}, vecResult[idx], rdata);
        busAccess(1'b0, regHi, '0, rdata);
        checkWord({tag, " HI"}, vecHi[idx], rdata);
        busAccess(1'b0, regLo, '0, rdata);
        checkWord({tag, " LO"}, vecLo[idx], rdata);
        busAccess(1'b0, regStatus, '0, rdata);
        checkStatus({tag, " status"}, vecStatus[idx], statusT'(rdata));
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (cycleLimit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        loadGolden();
        if (vecOpA.size() == 0) begin
            stopOnError("Golden file holds no vectors");
        end
        cycleLimit = 40 * vecOpA.size() + 100;
        loaded     = 1'b1;
        wait (rstN === 1'b1);
        checkResetState();
        for (int i = 0; i < vecOpA.size(); i++) begin
            runVector(i);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsExecUnit.f
verilog/mipsExecPkg.sv
verilog/execIf.sv
verilog/instrDecode.sv
verilog/aluControl.sv
verilog/aluExecute.sv
verilog/resultRegs.sv
verilog/wbExecSlave.sv
verilog/mipsExecUnit.sv
verif/tbClock.sv
verif/mipsExecUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, then run the model from the project root
cd "$(dirname "$0")" &&
    verilator --binary --assert --top-module mipsExecUnitTb -f mipsExecUnit.f \
        -o mipsExecUnitSim &&
    ./obj_dir/mipsExecUnitSim ||
    { echo "Simulation did not pass" >&2; exit 1; }

// File: verif/execGolden.txt
# opA      opB      instr    result   hi       lo       status   (all hex)
# Result, HI and LO carry over from line to line; status bit0 taken, bit1 illegal
00000005 00000007 00221820 0000000c 00000000 00000000 00000000
00000000 00000001 00221823 ffffffff 00000000 00000000 00000000
f0f0f0f0 ff00ff00 00221824 f000f000 00000000 00000000 00000000
f0f0f0f0 0f000f00 00221825 fff0fff0 00000000 00000000 00000000
aaaa5555 ffff0000 00221826 55555555 00000000 00000000 00000000
0000ffff 00ff0000 00221827 ff000000 00000000 00000000 00000000
00000010 12345678 2022fffe 0000000e 00000000 00000000 00000000
00010000 00000000 24228000 00008000 00000000 00000000 00000000
ffffffff 00000000 3022f0f0 0000f0f0 00000000 00000000 00000000
12340000 00000000 34228001 12348001 00000000 00000000 00000000
ffff1234 00000000 3822ffff ffffedcb 00000000 00000000 00000000
00000005 00000000 2822ffff 00000000 00000000 00000000 00000000
00010000 00000000 2c22ffff 00000001 00000000 00000000 00000000
00000001 80000000 0022182a 00000000 00000000 00000000 00000000
00000001 80000000 0022182b 00000001 00000000 00000000 00000000
00000000 0000000f 00221900 000000f0 00000000 00000000 00000000
00000000 80000000 00021a02 00800000 00000000 00000000 00000000
00000000 80000000 00021a03 ff800000 00000000 00000000 00000000
00000000 12345678 00221902 81234567 00000000 00000000 00000000
00000024 00000003 00221804 00000030 00000000 00000000 00000000
00000010 abcd0000 00221806 0000abcd 00000000 00000000 00000000
00000004 f0000000 00221807 ff000000 00000000 00000000 00000000
00000008 12345678 00221846 78123456 00000000 00000000 00000000
00000000 00000000 3c02abcd abcd0000 00000000 00000000 00000000
00000000 00000080 7c021c20 ffffff80 00000000 00000000 00000000
00000000 00008001 7c021e20 ffff8001 00000000 00000000 00000000
fffffffe 00000003 00221818 ffff8001 ffffffff fffffffa 00000000
ffffffff 00000002 00221819 ffff8001 00000001 fffffffe 00000000
00000002 00000003 70220000 ffff8001 00000002 00000004 00000000
ffffffff 00000005 70220004 ffff8001 00000002 00000009 00000000
fffffffd 00000007 70221802 ffffffeb 00000002 00000009 00000000
00000000 00000000 00001810 00000002 00000002 00000009 00000000
00000000 00000000 00001812 00000009 00000002 00000009 00000000
cafe0001 00000000 00200011 00000009 cafe0001 00000009 00000000
0bad0002 00000000 00200013 00000009 cafe0001 0bad0002 00000000
00000055 00000055 10220010 00000009 cafe0001 0bad0002 00000001
00000055 00000056 10220010 00000009 cafe0001 0bad0002 00000000
00000001 00000002 14220010 00000009 cafe0001 0bad0002 00000001
80000000 00000000 04200010 00000009 cafe0001 0bad0002 00000001
00000000 00000000 04210010 00000009 cafe0001 0bad0002 00000001
00000000 00000000 1c200010 00000009 cafe0001 0bad0002 00000000
00000000 00000000 18200010 00000009 cafe0001 0bad0002 00000001
00000001 00000001 08000010 00000009 cafe0001 0bad0002 00000002
00000001 00000001 0022180b 00000009 cafe0001 0bad0002 00000002
00000003 00000004 70221821 00000009 cafe0001 0bad0002 00000002
00000000 00000000 00001812 0bad0002 cafe0001 0bad0002 00000000
